// File: design/display_pkg.sv
`default_nettype none

package display_pkg;

    // -------------------------------------------------------------------------
    // Geometry
    // -------------------------------------------------------------------------
    localparam int screen_w_bits = 10;
    localparam int phy_w_bits    = 14;
    // One screen height, also one camera step in world lines
    localparam int screen_h      = 480;
    localparam int camera_bits   = 5;

    // Map band, screen columns inclusive
    localparam int map_x_lo  = 120;
    localparam int map_x_hi  = 599;
    // 16-pixel checker tiles
    localparam int tile_bits = 4;

    // Character box and eye placement
    localparam int char_w      = 42;
    localparam int char_h      = 52;
    localparam int sprite_bits = 6;
    localparam int eye_y_lo    = 8;
    localparam int eye_size    = 4;
    localparam int eye_x_left  = 10;
    localparam int eye_x_right = 28;
    localparam int frame_num   = 6;
    localparam int frame_bits  = 3;

    // Obstacle table
    localparam int obs_num       = 8;
    localparam int obs_idx_bits  = 3;
    localparam int obs_unit      = 10;
    localparam int obs_len_bits  = 4;
    localparam int cmd_data_bits = 32;

    // -------------------------------------------------------------------------
    // Palette
    // -------------------------------------------------------------------------
    localparam int rgb_bits = 12;
    localparam logic [rgb_bits-1:0] black  = 12'h000;
    localparam logic [rgb_bits-1:0] white  = 12'hFFF;
    localparam logic [rgb_bits-1:0] yellow = 12'h5FF;
    localparam logic [rgb_bits-1:0] green  = 12'h2A6;
    localparam logic [rgb_bits-1:0] brown  = 12'h820;
    localparam logic [rgb_bits-1:0] gray   = 12'h841;
    // Body colour per animation frame, entry 0 in the low bits
    localparam logic [frame_num-1:0][rgb_bits-1:0] char_palette = {
        12'hA21, 12'h088, 12'hE6E, 12'h808, 12'hF41, 12'hF80
    };

    // -------------------------------------------------------------------------
    // Types
    // -------------------------------------------------------------------------
    typedef enum logic {face_left, face_right} face_e;

    typedef enum logic [1:0] {
        op_set_char, op_set_obstacle, op_set_camera, op_clear_obstacles
    } scene_op_e;

    // Stage-1 winner, highest priority last
    typedef enum logic [2:0] {
        layer_blank, layer_backdrop, layer_map, layer_obstacle, layer_char
    } layer_e;

    typedef struct packed {
        logic [screen_w_bits-1:0] x;
        logic [screen_w_bits-1:0] y;
        logic                     video_on;
    } pixel_req_t;

    // Fills the 32-bit command data word exactly
    typedef struct packed {
        logic [phy_w_bits-1:0]   pos_x;
        logic [phy_w_bits-1:0]   pos_y;
        logic [obs_len_bits-1:0] blocks;
    } obstacle_t;

    typedef struct packed {
        logic [phy_w_bits-1:0] abs_x;
        logic [phy_w_bits-1:0] abs_y;
        face_e                 face;
    } char_state_t;

    typedef struct packed {
        scene_op_e                op;
        logic [obs_idx_bits-1:0]  index;
        logic [cmd_data_bits-1:0] data;
    } scene_cmd_t;

endpackage

`default_nettype wire

// File: design/scene_regs.sv
`default_nettype none

module scene_regs (
    input  logic                                sys_clk,
    input  logic                                sys_rst_n,
    input  logic                                scene_wr,
    input  display_pkg::scene_cmd_t             scene_cmd,
    input  logic                                frame_tick,
    output display_pkg::char_state_t            char_state,
    output display_pkg::obstacle_t              obstacles [display_pkg::obs_num],
    output logic [display_pkg::camera_bits-1:0] camera_y,
    output logic [display_pkg::frame_bits-1:0]  frame
);
    import display_pkg::*;

    // -------------------------------------------------------------------------
    // Scene write decode
    // -------------------------------------------------------------------------
    // Command lands on the strobe edge, visible next cycle
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_state.abs_x <= '0;
            char_state.abs_y <= '0;
            char_state.face  <= face_right;
            for (int i = 0; i < obs_num; i++) begin
                obstacles[i] <= '0;
            end
            camera_y <= '0;
        end else if (scene_wr) begin
            case (scene_cmd.op)
                // Character fields sit in the low data bits
                op_set_char: begin
                    char_state <= char_state_t'(scene_cmd.data[$bits(char_state_t)-1:0]);
                end
                op_set_obstacle: begin
                    obstacles[scene_cmd.index] <= obstacle_t'(scene_cmd.data);
                end
                op_set_camera: begin
                    camera_y <= scene_cmd.data[camera_bits-1:0];
                end
                // Zero blocks means the entry covers nothing
                op_clear_obstacles: begin
                    for (int i = 0; i < obs_num; i++) begin
                        obstacles[i].blocks <= '0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Animation frame, 0 to frame_num-1 then wrap
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            frame <= '0;
        end else if (frame_tick) begin
            if (frame == frame_bits'(frame_num - 1)) begin
                frame <= '0;
            end else begin
                frame <= frame + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/map_pattern.sv
`default_nettype none

module map_pattern (
    input  logic [display_pkg::phy_w_bits-1:0] world_x,
    input  logic [display_pkg::phy_w_bits-1:0] world_y,
    output logic [display_pkg::rgb_bits-1:0]   rgb
);
    import display_pkg::*;

    // Tile index per axis
    logic [phy_w_bits-tile_bits-1:0] tile_x;
    logic [phy_w_bits-tile_bits-1:0] tile_y;
    // One extra bit keeps the sum exact
    logic [phy_w_bits-tile_bits:0]   tile_sum;

    assign tile_x = world_x[phy_w_bits-1:tile_bits];
    assign tile_y = world_y[phy_w_bits-1:tile_bits];
    assign tile_sum = tile_x + tile_y;

    // Even sum green, odd sum brown
    always_comb begin
        if (tile_sum[0]) begin
            rgb = brown;
        end else begin
            rgb = green;
        end
    end

endmodule

`default_nettype wire

// File: design/char_sprite.sv
`default_nettype none

module char_sprite (
    input  logic [display_pkg::sprite_bits-1:0] rel_x,
    input  logic [display_pkg::sprite_bits-1:0] rel_y,
    input  display_pkg::face_e                  face,
    input  logic [display_pkg::frame_bits-1:0]  frame,
    output logic [display_pkg::rgb_bits-1:0]    rgb
);
    import display_pkg::*;

    logic                   border;
    logic                   eye;
    logic [sprite_bits-1:0] eye_x;

    // One-pixel outline on all four sides
    assign border = (rel_x == '0) || (rel_x == sprite_bits'(char_w - 1))
                 || (rel_y == '0) || (rel_y == sprite_bits'(char_h - 1));

    // Eye column follows the facing
    assign eye_x = (face == face_right) ? sprite_bits'(eye_x_right)
                                        : sprite_bits'(eye_x_left);

    // Square eye, same rows either way
    assign eye = (rel_y >= eye_y_lo) && (rel_y < eye_y_lo + eye_size)
              && (rel_x >= eye_x) && (rel_x < eye_x + eye_size);

    // -------------------------------------------------------------------------
    // Pixel colour
    // -------------------------------------------------------------------------
    always_comb begin
        if (border) begin
            rgb = black;
        end else if (eye) begin
            rgb = white;
        end else if (frame < frame_num) begin
            // Body tint cycles with the animation
            rgb = char_palette[frame];
        end else begin
            // Unused frame codes
            rgb = black;
        end
    end

endmodule

`default_nettype wire

// File: design/obstacle_hit.sv
`default_nettype none

module obstacle_hit (
    input  logic [display_pkg::phy_w_bits-1:0] world_x,
    input  logic [display_pkg::phy_w_bits-1:0] world_y,
    input  display_pkg::obstacle_t             obstacles [display_pkg::obs_num],
    output logic                               hit
);
    import display_pkg::*;

    // Per-entry cover flags
    logic [obs_num-1:0] entry_hit;

    genvar i;
    generate
        for (i = 0; i < obs_num; i++) begin : g_entry
            logic [phy_w_bits-1:0] extent;
            logic [phy_w_bits-1:0] dx;
            logic [phy_w_bits-1:0] dy;

            // Width in pixels, zero for an empty entry
            assign extent = phy_w_bits'(obstacles[i].blocks * obs_unit);

            // Offsets only meaningful once past the left and top edges
            assign dx = world_x - obstacles[i].pos_x;
            assign dy = world_y - obstacles[i].pos_y;

            // One block tall
            assign entry_hit[i] = (world_x >= obstacles[i].pos_x) && (dx < extent)
                               && (world_y >= obstacles[i].pos_y) && (dy < obs_unit);
        end
    endgenerate

    // Any entry wins
    assign hit = |entry_hit;

endmodule

`default_nettype wire

// File: design/pixel_gen.sv
`default_nettype none

module pixel_gen (
    input  logic                                sys_clk,
    input  logic                                sys_rst_n,
    input  logic                                pix_valid,
    input  display_pkg::pixel_req_t             pix_req,
    input  display_pkg::char_state_t            char_state,
    input  display_pkg::obstacle_t              obstacles [display_pkg::obs_num],
    input  logic [display_pkg::camera_bits-1:0] camera_y,
    input  logic [display_pkg::frame_bits-1:0]  frame,
    output logic                                rgb_valid,
    output logic [display_pkg::rgb_bits-1:0]    rgb
);
    import display_pkg::*;

    logic [phy_w_bits-1:0] cam_offset;
    logic [phy_w_bits-1:0] world_x;
    logic [phy_w_bits-1:0] world_y;
    logic [phy_w_bits-1:0] char_dx;
    logic [phy_w_bits-1:0] char_dy;
    logic                  char_on;
    logic                  map_on;
    logic                  obs_on;
    logic [rgb_bits-1:0]   map_rgb;
    logic [rgb_bits-1:0]   char_rgb;
    layer_e                layer;

    // Stage-1 registers
    logic                  s1_valid;
    layer_e                s1_layer;
    logic [rgb_bits-1:0]   s1_map_rgb;
    logic [rgb_bits-1:0]   s1_char_rgb;
    logic [rgb_bits-1:0]   final_rgb;

    // -------------------------------------------------------------------------
    // Stage 1: world coordinates and layer flags
    // -------------------------------------------------------------------------
    // Camera scrolls in whole screens
    assign cam_offset = phy_w_bits'(camera_y * screen_h);
    assign world_x = phy_w_bits'(pix_req.x);
    assign world_y = phy_w_bits'(pix_req.y) + cam_offset;

    // Sprite-relative position, valid inside the box only
    assign char_dx = world_x - char_state.abs_x;
    assign char_dy = world_y - char_state.abs_y;
    assign char_on = (world_x >= char_state.abs_x) && (char_dx < char_w)
                  && (world_y >= char_state.abs_y) && (char_dy < char_h);

    // Band test on screen x
    assign map_on = (pix_req.x >= map_x_lo) && (pix_req.x <= map_x_hi);

    map_pattern u_map (
        .world_x (world_x),
        .world_y (world_y),
        .rgb     (map_rgb)
    );

    char_sprite u_char (
        .rel_x (char_dx[sprite_bits-1:0]),
        .rel_y (char_dy[sprite_bits-1:0]),
        .face  (char_state.face),
        .frame (frame),
        .rgb   (char_rgb)
    );

    obstacle_hit u_obs (
        .world_x   (world_x),
        .world_y   (world_y),
        .obstacles (obstacles),
        .hit       (obs_on)
    );

    // Priority: blanking, sprite, obstacle, map, backdrop
    always_comb begin
        if (!pix_req.video_on) begin
            layer = layer_blank;
        end else if (char_on) begin
            layer = layer_char;
        end else if (obs_on) begin
            layer = layer_obstacle;
        end else if (map_on) begin
            layer = layer_map;
        end else begin
            layer = layer_backdrop;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            s1_valid <= 1'b0;
            s1_layer <= layer_blank;
        end else begin
            s1_valid <= pix_valid;
            if (pix_valid) begin
                s1_layer <= layer;
            end
        end
    end

    // Layer colours ride along with the choice
    always_ff @(posedge sys_clk) begin
        if (pix_valid) begin
            s1_map_rgb  <= map_rgb;
            s1_char_rgb <= char_rgb;
        end
    end

    // -------------------------------------------------------------------------
    // Stage 2: layer to colour
    // -------------------------------------------------------------------------
    always_comb begin
        case (s1_layer)
            layer_char:     final_rgb = s1_char_rgb;
            layer_obstacle: final_rgb = gray;
            layer_map:      final_rgb = s1_map_rgb;
            layer_backdrop: final_rgb = yellow;
            default:        final_rgb = black;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rgb_valid <= 1'b0;
            rgb       <= black;
        end else begin
            rgb_valid <= s1_valid;
            // Hold the last colour between requests
            if (s1_valid) begin
                rgb <= final_rgb;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/game_display_top.sv
`default_nettype none

module game_display_top (
    input  logic                             sys_clk,
    input  logic                             sys_rst_n,
    input  logic                             scene_wr,
    input  display_pkg::scene_cmd_t          scene_cmd,
    input  logic                             frame_tick,
    input  logic                             pix_valid,
    input  display_pkg::pixel_req_t          pix_req,
    output logic                             rgb_valid,
    output logic [display_pkg::rgb_bits-1:0] rgb
);
    import display_pkg::*;

    // Scene levels into the pixel path
    char_state_t            char_state;
    obstacle_t              obstacles [obs_num];
    logic [camera_bits-1:0] camera_y;
    logic [frame_bits-1:0]  frame;

    scene_regs u_scene (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .scene_wr   (scene_wr),
        .scene_cmd  (scene_cmd),
        .frame_tick (frame_tick),
        .char_state (char_state),
        .obstacles  (obstacles),
        .camera_y   (camera_y),
        .frame      (frame)
    );

    // Two-cycle request to colour
    pixel_gen u_pixel (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .pix_valid  (pix_valid),
        .pix_req    (pix_req),
        .char_state (char_state),
        .obstacles  (obstacles),
        .camera_y   (camera_y),
        .frame      (frame),
        .rgb_valid  (rgb_valid),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// File: tb/game_display_properties.sv
`default_nettype none

module game_display_properties (
    input wire logic                             sys_clk,
    input wire logic                             sys_rst_n,
    input wire logic                             pix_valid,
    input wire display_pkg::pixel_req_t          pix_req,
    input wire logic                             rgb_valid,
    input wire logic [display_pkg::rgb_bits-1:0] rgb
);
    import display_pkg::*;

    // Fixed two-cycle latency, both directions
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pix_valid |-> ##2 rgb_valid)
        else $error("Request not answered two cycles later");

    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        rgb_valid |-> $past(pix_valid, 2))
        else $error("Colour strobe without a request two cycles earlier");

    // Quiet output while in reset
    assert property (@(posedge sys_clk) !sys_rst_n |-> !rgb_valid)
        else $error("Colour strobe during reset");

    // Blanked request gives black
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (pix_valid && !pix_req.video_on) |-> ##2 (rgb == black))
        else $error("Blanked pixel not black");

endmodule

bind pixel_gen game_display_properties u_props (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .pix_valid (pix_valid),
    .pix_req   (pix_req),
    .rgb_valid (rgb_valid),
    .rgb       (rgb)
);

`default_nettype wire

// File: tb/game_display_tb.sv
`default_nettype none

module game_display_tb;
    import display_pkg::*;

    localparam int    reset_cycles = 5;
    localparam int    slack_cycles = 20;
    localparam string golden_path  = "tb/game_display_golden.txt";

    logic                sys_clk;
    logic                sys_rst_n;
    logic                scene_wr;
    scene_cmd_t          scene_cmd;
    logic                frame_tick;
    logic                pix_valid;
    pixel_req_t          pix_req;
    logic                rgb_valid;
    logic [rgb_bits-1:0] rgb;

    // Golden commands with their file line numbers
    string               golden_lines [$];
    int                  golden_line_nos [$];
    // Outstanding pixel requests, oldest first
    logic [rgb_bits-1:0] expected_q [$];
    string               name_q [$];
    int                  cycle_count = 0;
    int                  cycle_limit = 0;

    game_display_top u_dut (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .scene_wr   (scene_wr),
        .scene_cmd  (scene_cmd),
        .frame_tick (frame_tick),
        .pix_valid  (pix_valid),
        .pix_req    (pix_req),
        .rgb_valid  (rgb_valid),
        .rgb        (rgb)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // -------------------------------------------------------------------------
    // Failure and comparison
    // -------------------------------------------------------------------------
    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [rgb_bits-1:0] expected,
                               input logic [rgb_bits-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // Comment and blank lines are dropped here
    task automatic read_golden();
        int    fd;
        int    line_no;
        string line;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", golden_path);
            fail_run();
        end
        line_no = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() > 1 && line.getc(0) != "#") begin
                golden_lines.push_back(line);
                golden_line_nos.push_back(line_no);
            end
        end
        $fclose(fd);
    endtask

    // One golden command for one cycle
    task automatic apply_command(input string line, input int line_no);
        int                  op;
        int                  idx;
        int                  x;
        int                  y;
        int                  von;
        logic [31:0]         data;
        logic [rgb_bits-1:0] exp_rgb;
        scene_wr   = 1'b0;
        frame_tick = 1'b0;
        pix_valid  = 1'b0;
        case (line.getc(0))
            "W": begin
                if ($sscanf(line, "W %d %d %h", op, idx, data) != 3) begin
                    $display("Malformed scene write on golden line %0d", line_no);
                    fail_run();
                end
                scene_cmd.op    = scene_op_e'(op);
                scene_cmd.index = obs_idx_bits'(idx);
                scene_cmd.data  = data;
                scene_wr        = 1'b1;
            end
            "T": frame_tick = 1'b1;
            "P": begin
                if ($sscanf(line, "P %d %d %d %h", x, y, von, exp_rgb) != 4) begin
                    $display("Malformed pixel request on golden line %0d", line_no);
                    fail_run();
                end
                pix_req.x        = screen_w_bits'(x);
                pix_req.y        = screen_w_bits'(y);
                pix_req.video_on = von[0];
                pix_valid        = 1'b1;
                expected_q.push_back(exp_rgb);
                name_q.push_back($sformatf("golden line %0d", line_no));
            end
            default: begin
                $display("Unknown command on golden line %0d", line_no);
                fail_run();
            end
        endcase
    endtask

    // -------------------------------------------------------------------------
    // Response monitor, sampled mid-cycle
    // -------------------------------------------------------------------------
    always @(negedge sys_clk) begin
        if (sys_rst_n && rgb_valid) begin
            if (expected_q.size() == 0) begin
                $display("A colour came out with no pixel request waiting for it");
                fail_run();
            end else begin
                check_value(name_q.pop_front(), expected_q.pop_front(), rgb);
            end
        end
    end

    // Limit from the command count
    initial begin
        wait (cycle_limit > 0);
        forever begin
            @(posedge sys_clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("Timeout after %0d cycles", cycle_limit);
                fail_run();
            end
        end
    end

    initial begin
        sys_rst_n  = 1'b0;
        scene_wr   = 1'b0;
        scene_cmd  = '0;
        frame_tick = 1'b0;
        pix_valid  = 1'b0;
        pix_req    = '0;
        read_golden();
        cycle_limit = golden_lines.size() + reset_cycles + slack_cycles;
        repeat (reset_cycles) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;
        foreach (golden_lines[i]) begin
            @(posedge sys_clk);
            #1;
            apply_command(golden_lines[i], golden_line_nos[i]);
        end
        @(posedge sys_clk);
        #1;
        scene_wr   = 1'b0;
        frame_tick = 1'b0;
        pix_valid  = 1'b0;
        // Drain, then watch for stray responses
        while (expected_q.size() != 0) @(negedge sys_clk);
        repeat (4) @(posedge sys_clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/game_display_golden.txt
# W op index data_hex | T (frame tick) | P x y video_on expected_rgb_hex
# op: 0 set_char, 1 set_obstacle, 2 set_camera, 3 clear_obstacles
P 5 5 1 F80
W 0 0 6400C9
W 1 0 02D00783
P 205 125 1 F80
P 190 125 1 841
P 150 125 1 2A6
P 166 125 1 820
P 50 125 1 5FF
P 205 125 0 000
P 200 110 1 000
P 241 151 1 000
P 228 108 1 FFF
P 232 111 1 F80
W 0 0 6400C8
P 228 108 1 F80
P 210 108 1 FFF
T
P 205 125 1 F41
T
T
T
T
P 205 125 1 A21
T
P 205 125 1 F80
W 1 1 04B00C82
W 1 2 06400C80
P 319 205 1 841
P 320 205 1 2A6
P 400 205 1 820
W 3 0 0
P 190 125 1 2A6
P 310 205 1 820
W 2 0 1
P 205 125 1 820
W 0 0 6404B1
P 205 125 1 F80
P 228 128 1 FFF

// File: game_display_top.f
design/display_pkg.sv
design/scene_regs.sv
design/map_pattern.sv
design/char_sprite.sv
design/obstacle_hit.sv
design/pixel_gen.sv
design/game_display_top.sv
tb/game_display_properties.sv
tb/game_display_tb.sv
